// ==== compile.f ====
mipsPkg.sv
pipeIf.sv
fetchStage.sv
decodeStage.sv
regFile.sv
hazardUnit.sv
executeStage.sv
memWbStage.sv
cpuCore.sv
tbCpu.sv

// ==== cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
	input  logic        clk,
	input  logic        arstN,
	output logic [31:0] pcF,
	input  logic [31:0] instrF,
	output logic        memWriteM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input  logic [31:0] readDataM,
	output logic [31:0] debugWbPc,
	output logic        debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	import mipsPkg::*;

	// hazard levels
	logic        stallF, stallD, flushE;
	logic        forwardAD, forwardBD;
	fwdSel       forwardAE, forwardBE;
	// fetch/decode
	logic        pcSrcD, jumpD, branchD;
	logic [31:0] pcBranchD, pcJumpD, instrD, pcPlus4D, pcD;
	logic [4:0]  rsD, rtD;
	logic [31:0] rfA, rfB;
	logic [31:0] resultW;

	decExIf dx (.clk(clk));
	exMemIf xm ();
	memWbIf wb ();

	fetchStage u_fetchStage (
		.clk(clk), .arstN(arstN), .stallF(stallF), .stallD(stallD),
		.pcSrcD(pcSrcD), .jumpD(jumpD), .pcBranchD(pcBranchD), .pcJumpD(pcJumpD),
		.instrF(instrF), .pcF(pcF), .instrD(instrD), .pcPlus4D(pcPlus4D), .pcD(pcD)
	);

	decodeStage u_decodeStage (
		.clk(clk), .arstN(arstN), .instrD(instrD), .pcPlus4D(pcPlus4D), .pcD(pcD),
		.rfA(rfA), .rfB(rfB), .aluOutM(aluOutM),
		.forwardAD(forwardAD), .forwardBD(forwardBD), .flushE(flushE),
		.rsD(rsD), .rtD(rtD), .branchD(branchD), .pcSrcD(pcSrcD), .jumpD(jumpD),
		.pcBranchD(pcBranchD), .pcJumpD(pcJumpD), .dx(dx.src)
	);

	regFile u_regFile (
		.clk(clk), .rsD(rsD), .rtD(rtD), .wb(wb.dst), .rfA(rfA), .rfB(rfB)
	);

	hazardUnit u_hazardUnit (
		.dx(dx.dst), .xm(xm.dst), .wb(wb.dst), .rsD(rsD), .rtD(rtD), .branchD(branchD),
		.stallF(stallF), .stallD(stallD), .flushE(flushE),
		.forwardAE(forwardAE), .forwardBE(forwardBE),
		.forwardAD(forwardAD), .forwardBD(forwardBD)
	);

	executeStage u_executeStage (
		.clk(clk), .arstN(arstN), .forwardAE(forwardAE), .forwardBE(forwardBE),
		.resultW(resultW), .dx(dx.dst), .xm(xm.src)
	);

	memWbStage u_memWbStage (
		.clk(clk), .arstN(arstN), .xm(xm.dst), .readDataM(readDataM),
		.memWriteM(memWriteM), .aluOutM(aluOutM), .writeDataM(writeDataM),
		.wb(wb.src), .resultW(resultW),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
	input  logic        clk,
	input  logic        arstN,
	input  logic [31:0] instrD,
	input  logic [31:0] pcPlus4D,
	input  logic [31:0] pcD,
	input  logic [31:0] rfA,
	input  logic [31:0] rfB,
	input  logic [31:0] aluOutM,
	input  logic        forwardAD,
	input  logic        forwardBD,
	input  logic        flushE,
	output logic [4:0]  rsD,
	output logic [4:0]  rtD,
	output logic        branchD,
	output logic        pcSrcD,
	output logic        jumpD,
	output logic [31:0] pcBranchD,
	output logic [31:0] pcJumpD,
	decExIf.src         dx
);
	import mipsPkg::*;

	instrWord    ins;
	logic [5:0]  op;
	logic        isR;
	logic        isBne;
	logic        rFnOk;
	// {regWrite, memToReg, memWrite, aluSrc, regDst}
	logic [4:0]  ctlD;
	aluOp        rAlu;
	aluOp        aluCtlD;
	logic [31:0] signImmD;
	logic [31:0] cmpA;
	logic [31:0] cmpB;

	assign ins   = instrD;
	assign op    = ins.rType.op;
	assign isR   = (op == opRtype);
	assign isBne = (op == opBne);
	assign jumpD = (op == opJ);
	assign branchD = (op == opBeq) || isBne;

	// unread fields go out as $0 so they never match a hazard
	assign rsD = (jumpD || op == opLui) ? 5'd0 : ins.rType.rs;
	assign rtD = (isR || branchD || op == opSw) ? ins.rType.rt : 5'd0;

	always_comb begin
		rAlu  = aluAdd;
		rFnOk = 1'b1;
		case (ins.rType.funct)
			fnAddu:  rAlu = aluAdd;
			fnSubu:  rAlu = aluSub;
			fnAnd:   rAlu = aluAnd;
			fnOr:    rAlu = aluOr;
			fnSlt:   rAlu = aluSlt;
			fnSll:   rAlu = aluSll;
			default: rFnOk = 1'b0;
		endcase
	end

	// unknown opcodes write nothing
	always_comb begin
		case (op)
			opRtype:               ctlD = {rFnOk, 4'b0001};
			opAddiu, opOri, opLui: ctlD = 5'b10010;
			opLw:                  ctlD = 5'b11010;
			opSw:                  ctlD = 5'b00110;
			default:               ctlD = 5'b00000;
		endcase
	end

	assign aluCtlD = isR ? rAlu : (op == opOri) ? aluOr : (op == opLui) ? aluLui : aluAdd;

	// ori zero-extends and the rest sign-extend
	assign signImmD = (op == opOri) ? {16'd0, ins.iType.imm16}
		: {{16{ins.iType.imm16[15]}}, ins.iType.imm16};

	assign pcBranchD = pcPlus4D + {signImmD[29:0], 2'b00};
	assign pcJumpD   = {pcPlus4D[31:28], ins.jType.target26, 2'b00};

	// early branch compare on the forwarded memory-stage alu result
	assign cmpA   = forwardAD ? aluOutM : rfA;
	assign cmpB   = forwardBD ? aluOutM : rfB;
	assign pcSrcD = branchD && ((cmpA == cmpB) != isBne);

	////////////////////////////////////////////////////////////////////////////
	// decode -> execute register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			{dx.regWrite, dx.memToReg, dx.memWrite} <= 3'b000;
		end else begin
			// bubble on flush
			{dx.regWrite, dx.memToReg, dx.memWrite} <= flushE ? 3'b000 : ctlD[4:2];
		end
	end

	always_ff @(posedge clk) begin
		dx.aluSrc  <= ctlD[1];
		dx.regDst  <= ctlD[0];
		dx.aluCtl  <= aluCtlD;
		dx.srcA    <= rfA;
		dx.srcB    <= rfB;
		dx.signImm <= signImmD;
		dx.rs      <= rsD;
		dx.rt      <= ins.rType.rt;
		dx.rd      <= ins.rType.rd;
		dx.shamt   <= ins.rType.shamt;
		dx.pc      <= pcD;
	end

	// the delay slot behind an accepted redirect is never a branch or jump
	assert property (@(posedge clk) disable iff (!arstN)
		(jumpD || pcSrcD) && !flushE |=> !(jumpD || branchD));

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
	input  logic           clk,
	input  logic           arstN,
	input  mipsPkg::fwdSel forwardAE,
	input  mipsPkg::fwdSel forwardBE,
	input  logic [31:0]    resultW,
	decExIf.dst            dx,
	exMemIf.src            xm
);
	import mipsPkg::*;

	logic [31:0] srcAE;
	logic [31:0] fwdBE;
	logic [31:0] srcBE;
	logic [31:0] aluOutE;
	logic [4:0]  writeRegE;

	// operand bypass
	always_comb begin
		case (forwardAE)
			fwdMem:  srcAE = xm.aluOut;
			fwdWb:   srcAE = resultW;
			default: srcAE = dx.srcA;
		endcase
		case (forwardBE)
			fwdMem:  fwdBE = xm.aluOut;
			fwdWb:   fwdBE = resultW;
			default: fwdBE = dx.srcB;
		endcase
	end

	assign srcBE     = dx.aluSrc ? dx.signImm : fwdBE;
	assign writeRegE = dx.regDst ? dx.rd : dx.rt;

	always_comb begin
		case (dx.aluCtl)
			aluAdd:  aluOutE = srcAE + srcBE;
			aluSub:  aluOutE = srcAE - srcBE;
			aluAnd:  aluOutE = srcAE & srcBE;
			aluOr:   aluOutE = srcAE | srcBE;
			aluSlt:  aluOutE = {31'd0, $signed(srcAE) < $signed(srcBE)};
			// shift amount from the instruction, not from rs
			aluSll:  aluOutE = srcBE << dx.shamt;
			aluLui:  aluOutE = {srcBE[15:0], 16'd0};
			default: aluOutE = '0;
		endcase
	end

	// writes to $0 dropped here, so they never forward or reach the debug port
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			{xm.regWrite, xm.memToReg, xm.memWrite} <= 3'b000;
		end else begin
			xm.regWrite <= dx.regWrite && (writeRegE != 5'd0);
			xm.memToReg <= dx.memToReg;
			xm.memWrite <= dx.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		xm.aluOut    <= aluOutE;
		xm.writeData <= fwdBE;
		xm.writeReg  <= writeRegE;
		xm.pc        <= dx.pc;
	end

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
	input  logic        clk,
	input  logic        arstN,
	input  logic        stallF,
	input  logic        stallD,
	input  logic        pcSrcD,
	input  logic        jumpD,
	input  logic [31:0] pcBranchD,
	input  logic [31:0] pcJumpD,
	input  logic [31:0] instrF,
	output logic [31:0] pcF,
	output logic [31:0] instrD,
	output logic [31:0] pcPlus4D,
	output logic [31:0] pcD
);
	import mipsPkg::*;

	logic [31:0] pcPlus4F;
	logic [31:0] pcNext;

	assign pcPlus4F = pcF + 32'd4;
	// redirect comes from decode, so the delay slot is already in fetch
	assign pcNext = jumpD ? pcJumpD : (pcSrcD ? pcBranchD : pcPlus4F);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= resetPc;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	// fetch -> decode, all-zero word decodes as a nop
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcPlus4D <= pcPlus4F;
			pcD      <= pcF;
		end
	end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
	decExIf.dst            dx,
	exMemIf.dst            xm,
	memWbIf.dst            wb,
	input  logic [4:0]     rsD,
	input  logic [4:0]     rtD,
	input  logic           branchD,
	output logic           stallF,
	output logic           stallD,
	output logic           flushE,
	output mipsPkg::fwdSel forwardAE,
	output mipsPkg::fwdSel forwardBE,
	output logic           forwardAD,
	output logic           forwardBD
);
	import mipsPkg::*;

	logic [4:0] writeRegE;
	logic       hitE;
	logic       hitM;
	logic       lwStall;
	logic       branchStall;

	function automatic fwdSel pickFwd(input logic [4:0] src);
		fwdSel sel;
		sel = fwdReg;
		if (src != 5'd0 && wb.regWrite && src == wb.writeReg) begin
			sel = fwdWb;
		end
		// memory stage holds the younger value
		if (src != 5'd0 && xm.regWrite && src == xm.writeReg) begin
			sel = fwdMem;
		end
		return sel;
	endfunction

	always_comb begin
		forwardAE = pickFwd(dx.rs);
		forwardBE = pickFwd(dx.rt);
	end

	// branch operands take only an alu result since loads are stalled
	assign forwardAD = (rsD != 5'd0) && xm.regWrite && (rsD == xm.writeReg);
	assign forwardBD = (rtD != 5'd0) && xm.regWrite && (rtD == xm.writeReg);

	assign writeRegE = dx.regDst ? dx.rd : dx.rt;
	assign hitE = (writeRegE != 5'd0) && (writeRegE == rsD || writeRegE == rtD);
	assign hitM = (xm.writeReg != 5'd0) && (xm.writeReg == rsD || xm.writeReg == rtD);

	assign lwStall     = dx.memToReg && hitE;
	assign branchStall = branchD && ((dx.regWrite && hitE) || (xm.memToReg && hitM));

	// hold fetch and decode and send a bubble into execute
	assign stallF = lwStall || branchStall;
	assign stallD = stallF;
	assign flushE = stallF;

	// no stall lasts longer than two cycles
	assert property (@(posedge dx.clk) stallF ##1 stallF |=> !stallF);

endmodule

// ==== memWbStage.sv ====
`timescale 1ns/1ps

module memWbStage (
	input  logic        clk,
	input  logic        arstN,
	exMemIf.dst         xm,
	input  logic [31:0] readDataM,
	output logic        memWriteM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	memWbIf.src         wb,
	output logic [31:0] resultW,
	output logic [31:0] debugWbPc,
	output logic        debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	logic        regWriteW;
	logic        memToRegW;
	logic [31:0] aluOutW;
	logic [31:0] readDataW;
	logic [4:0]  writeRegW;
	logic [31:0] pcW;

	// data memory port, read data returns in the same cycle
	assign memWriteM  = xm.memWrite;
	assign aluOutM    = xm.aluOut;
	assign writeDataM = xm.writeData;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			regWriteW <= xm.regWrite;
			memToRegW <= xm.memToReg;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW   <= xm.aluOut;
		readDataW <= readDataM;
		writeRegW <= xm.writeReg;
		pcW       <= xm.pc;
	end

	assign resultW = memToRegW ? readDataW : aluOutW;

	assign wb.regWrite = regWriteW;
	assign wb.writeReg = writeRegW;
	assign wb.result   = resultW;

	// one pulse per retiring register write
	assign debugWbPc      = pcW;
	assign debugWbRfWen   = regWriteW;
	assign debugWbRfWnum  = writeRegW;
	assign debugWbRfWdata = resultW;

	// decoder never marks a store as a load
	assert property (@(posedge clk) disable iff (!arstN) !(xm.memWrite && xm.memToReg));

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

	// primary opcodes
	localparam logic [5:0] opRtype = 6'b000000;
	localparam logic [5:0] opJ     = 6'b000010;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opBne   = 6'b000101;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opOri   = 6'b001101;
	localparam logic [5:0] opLui   = 6'b001111;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opSw    = 6'b101011;

	// funct field, only meaningful under opRtype
	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnSlt  = 6'b101010;

	// first fetch address after reset
	localparam logic [31:0] resetPc = 32'h0000_0000;

	typedef enum logic [3:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluLui} aluOp;

	// operand source for execute
	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSel;

	////////////////////////////////////////////////////////////////////////////
	// instruction word views
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFmt;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target26;
	} jFmt;

	// same 32 bits, three decodings
	typedef union packed {
		rFmt rType;
		iFmt iType;
		jFmt jType;
	} instrWord;

endpackage

// ==== pipeIf.sv ====
`timescale 1ns/1ps

// decode -> execute bundle, clock carried for checkers on the reading side
interface decExIf (input logic clk);
	import mipsPkg::*;

	logic        regWrite;
	logic        memToReg;
	logic        memWrite;
	logic        aluSrc;
	logic        regDst;
	aluOp        aluCtl;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] signImm;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  shamt;
	// instruction address, carried down to the debug port
	logic [31:0] pc;

	modport src (output regWrite, memToReg, memWrite, aluSrc, regDst, aluCtl,
		srcA, srcB, signImm, rs, rt, rd, shamt, pc);
	modport dst (input clk, regWrite, memToReg, memWrite, aluSrc, regDst, aluCtl,
		srcA, srcB, signImm, rs, rt, rd, shamt, pc);
endinterface

// execute -> memory bundle
interface exMemIf;
	logic        regWrite;
	logic        memToReg;
	logic        memWrite;
	logic [31:0] aluOut;
	logic [31:0] writeData;
	logic [4:0]  writeReg;
	logic [31:0] pc;

	modport src (output regWrite, memToReg, memWrite, aluOut, writeData, writeReg, pc);
	modport dst (input regWrite, memToReg, memWrite, aluOut, writeData, writeReg, pc);
endinterface

// writeback toward regfile and hazard logic
interface memWbIf;
	logic        regWrite;
	logic [4:0]  writeReg;
	logic [31:0] result;

	modport src (output regWrite, writeReg, result);
	modport dst (input regWrite, writeReg, result);
endinterface

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic [4:0]  rsD,
	input  logic [4:0]  rtD,
	memWbIf.dst         wb,
	output logic [31:0] rfA,
	output logic [31:0] rfB
);

	logic [31:0] regs [32];

	// falling-edge write, decode sees the new value before the next rising edge
	always_ff @(negedge clk) begin
		if (wb.regWrite && wb.writeReg != 5'd0) begin
			regs[wb.writeReg] <= wb.result;
		end
	end

	// $0 hardwired
	assign rfA = (rsD == 5'd0) ? 32'd0 : regs[rsD];
	assign rfB = (rtD == 5'd0) ? 32'd0 : regs[rtD];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module tbCpu -f compile.f -o simCpu &&
	./obj_dir/simCpu | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null ||
	{ echo "simulation did not pass"; exit 1; }

// ==== tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu;
	import mipsPkg::*;

	// program plus stalls stays well under a third of this
	localparam int cycleLimit = 400;

	logic        clk;
	logic        arstN;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic        memWriteM;
	logic [31:0] aluOutM;
	logic [31:0] writeDataM;
	logic [31:0] readDataM;
	logic [31:0] debugWbPc;
	logic        debugWbRfWen;
	logic [4:0]  debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	logic [31:0] imem [64];
	logic [31:0] dmem [16];
	logic [31:0] modelMem [16];
	logic [31:0] modelRegs [32];

	// expected writebacks and stores, in program order
	logic [31:0] expPc [64];
	logic [4:0]  expNum [64];
	logic [31:0] expData [64];
	logic [31:0] expAddr [16];
	logic [31:0] expStore [16];
	int          wbCount;
	int          wbIdx;
	int          stCount;
	int          stIdx;
	int          cycles;

	cpuCore u_cpuCore (
		.clk(clk), .arstN(arstN), .pcF(pcF), .instrF(instrF),
		.memWriteM(memWriteM), .aluOutM(aluOutM), .writeDataM(writeDataM),
		.readDataM(readDataM), .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	////////////////////////////////////////////////////////////////////////////
	// single-cycle memories
	////////////////////////////////////////////////////////////////////////////
	assign instrF    = imem[pcF[7:2]];
	assign readDataM = dmem[aluOutM[5:2]];

	always @(posedge clk) begin
		if (memWriteM) begin
			dmem[aluOutM[5:2]] <= writeDataM;
		end
	end

	// consumed entries of the expected lists
	always @(posedge clk) begin
		if (debugWbRfWen) begin
			wbIdx <= wbIdx + 1;
		end
		if (memWriteM) begin
			stIdx <= stIdx + 1;
		end
	end

	task automatic abortRun();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expV, actV);
		$display("[FAIL] %s expected %h actual %h", name, expV, actV);
		abortRun();
	endtask

	task automatic reportProblem(input string why);
		$display("%s", why);
		abortRun();
	endtask

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] encodeR(input logic [5:0] fn, input int rd, rs, rt, sh);
		return {opRtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	// operand order as in assembly: op rt, rs, imm
	function automatic logic [31:0] encodeI(input logic [5:0] op, input int rt, rs,
		input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [25:0] target);
		return {opJ, target};
	endfunction

	task automatic fillMemories();
		for (int i = 0; i < 64; i++) begin
			imem[i] = 32'd0;
		end
		// pattern spans the whole word address
		for (int i = 0; i < 16; i++) begin
			dmem[i]     = 32'h5a5a_0000 + 32'(i) * 32'h0101_0104;
			modelMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = 32'd0;
		end
	endtask

	task automatic loadProgram();
		logic [31:0] rng;
		logic [15:0] imm [8];
		rng = 32'h65b9_5ef5;
		for (int k = 0; k < 8; k++) begin
			rng    = nextRandom(rng);
			imm[k] = rng[15:0];
		end
		// alu chain, forwarding from memory and writeback
		imem[0]  = encodeI(opAddiu, 1, 0, imm[0]);
		imem[1]  = encodeI(opAddiu, 2, 0, imm[1]);
		imem[2]  = encodeR(fnAddu, 3, 1, 2, 0);
		imem[3]  = encodeR(fnSubu, 4, 3, 1, 0);
		imem[4]  = encodeR(fnAnd, 5, 3, 4, 0);
		imem[5]  = encodeR(fnOr, 6, 5, 2, 0);
		imem[6]  = encodeR(fnSlt, 7, 4, 3, 0);
		imem[7]  = encodeR(fnSll, 8, 0, 6, 3);
		imem[8]  = encodeI(opOri, 9, 8, imm[2]);
		imem[9]  = encodeI(opLui, 10, 0, imm[3]);
		// store, reload, load-use, then a dependent taken beq
		imem[10] = encodeI(opSw, 9, 0, 16'd8);
		imem[11] = encodeI(opLw, 11, 0, 16'd8);
		imem[12] = encodeR(fnAddu, 12, 11, 10, 0);
		imem[13] = encodeI(opBeq, 12, 12, 16'd2);
		imem[14] = encodeI(opAddiu, 13, 12, imm[4]);
		imem[15] = encodeI(opAddiu, 14, 0, 16'd1);
		// bne right behind a load, not taken
		imem[16] = encodeI(opLw, 15, 0, 16'd8);
		imem[17] = encodeI(opBne, 9, 15, 16'd3);
		imem[18] = encodeI(opAddiu, 16, 15, imm[5]);
		imem[19] = encodeI(opBne, 0, 16, 16'd2);
		imem[20] = encodeR(fnSubu, 17, 16, 1, 0);
		imem[21] = encodeI(opAddiu, 18, 0, 16'd2);
		imem[22] = encodeJ(26'd25);
		imem[23] = encodeI(opOri, 19, 17, imm[6]);
		imem[24] = encodeI(opAddiu, 20, 0, 16'd3);
		// load two ahead of a beq
		imem[25] = encodeI(opSw, 19, 0, 16'd12);
		imem[26] = encodeI(opLw, 21, 0, 16'd12);
		imem[27] = encodeI(opAddiu, 22, 0, imm[7]);
		imem[28] = encodeI(opBeq, 19, 21, 16'd1);
		imem[29] = encodeR(fnSll, 23, 0, 21, 2);
		// parking loop, delay slot is the zero word
		imem[30] = encodeJ(26'd30);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// architectural model, one instruction per step, delay slots honoured
	////////////////////////////////////////////////////////////////////////////
	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nextNpc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] v;
		logic [31:0] addr;
		logic [31:0] pc4;
		logic [4:0]  dst;
		logic        wr;
		logic        parked;
		pc     = resetPc;
		npc    = resetPc + 32'd4;
		parked = 1'b0;
		for (int step = 0; step < 64 && !parked; step++) begin
			w       = imem[pc[7:2]];
			a       = modelRegs[w[25:21]];
			b       = modelRegs[w[20:16]];
			se      = {{16{w[15]}}, w[15:0]};
			addr    = a + se;
			pc4     = pc + 32'd4;
			nextNpc = npc + 32'd4;
			wr      = 1'b1;
			dst     = w[20:16];
			v       = 32'd0;
			case (w[31:26])
				opRtype: begin
					dst = w[15:11];
					case (w[5:0])
						fnAddu:  v = a + b;
						fnSubu:  v = a - b;
						fnAnd:   v = a & b;
						fnOr:    v = a | b;
						fnSlt:   v = {31'd0, $signed(a) < $signed(b)};
						fnSll:   v = b << w[10:6];
						default: wr = 1'b0;
					endcase
				end
				opAddiu: v = a + se;
				opOri:   v = a | {16'd0, w[15:0]};
				opLui:   v = {w[15:0], 16'd0};
				opLw:    v = modelMem[addr[5:2]];
				opSw: begin
					wr = 1'b0;
					modelMem[addr[5:2]] = b;
					expAddr[stCount]    = addr;
					expStore[stCount]   = b;
					stCount++;
				end
				opBeq, opBne: begin
					wr = 1'b0;
					if ((a == b) == (w[31:26] == opBeq)) begin
						nextNpc = pc4 + {se[29:0], 2'b00};
					end
				end
				opJ: begin
					wr      = 1'b0;
					nextNpc = {pc4[31:28], w[25:0], 2'b00};
					// jump to itself ends the program
					parked  = (nextNpc == pc);
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				modelRegs[dst]   = v;
				expPc[wbCount]   = pc;
				expNum[wbCount]  = dst;
				expData[wbCount] = v;
				wbCount++;
			end
			pc  = npc;
			npc = nextNpc;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	assert property (@(posedge clk) !arstN |-> !memWriteM && !debugWbRfWen && pcF == resetPc)
		else reportProblem("core outputs not in reset state while reset is held");

	assert property (@(posedge clk) disable iff (!arstN) debugWbRfWen |-> wbIdx < wbCount)
		else reportProblem("writeback pulse beyond the end of the expected stream");

	assert property (@(posedge clk) disable iff (!arstN)
		debugWbRfWen && wbIdx < wbCount |-> debugWbPc == expPc[wbIdx])
		else reportMismatch("writeback pc", expPc[$sampled(wbIdx)], $sampled(debugWbPc));

	assert property (@(posedge clk) disable iff (!arstN)
		debugWbRfWen && wbIdx < wbCount |-> debugWbRfWnum == expNum[wbIdx])
		else reportMismatch("writeback register", {27'd0, expNum[$sampled(wbIdx)]},
			{27'd0, $sampled(debugWbRfWnum)});

	assert property (@(posedge clk) disable iff (!arstN)
		debugWbRfWen && wbIdx < wbCount |-> debugWbRfWdata == expData[wbIdx])
		else reportMismatch("writeback data", expData[$sampled(wbIdx)],
			$sampled(debugWbRfWdata));

	assert property (@(posedge clk) disable iff (!arstN) memWriteM |-> stIdx < stCount)
		else reportProblem("store issued that the program does not perform");

	assert property (@(posedge clk) disable iff (!arstN)
		memWriteM && stIdx < stCount |-> aluOutM == expAddr[stIdx])
		else reportMismatch("store address", expAddr[$sampled(stIdx)], $sampled(aluOutM));

	assert property (@(posedge clk) disable iff (!arstN)
		memWriteM && stIdx < stCount |-> writeDataM == expStore[stIdx])
		else reportMismatch("store data", expStore[$sampled(stIdx)], $sampled(writeDataM));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			reportProblem("run exceeded the cycle limit before all writebacks appeared");
		end
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arstN   = 1'b0;
		cycles  = 0;
		wbIdx   = 0;
		stIdx   = 0;
		wbCount = 0;
		stCount = 0;
		fillMemories();
		loadProgram();
		runModel();
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		wait (wbIdx == wbCount && stIdx == stCount);
		// parking loop must stay silent
		repeat (8) @(posedge clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule
